/* cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Major opcodes of the supported instructions
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // ALU operations, alu_pass_b forwards operand B (LUI)
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // Control transfer kinds
    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu,
        br_jal
    } branch_e;

    // ADDI x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

endpackage

/* pc_unit.sv */
`timescale 1ns/10ps

module pc_unit #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           cache_stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    output cpu_pkg::word_t pc
);

    cpu_pkg::word_t pc_next;

    // Stall wins over redirect, redirect wins over the increment
    always_comb begin
        if (cache_stall) begin
            pc_next = pc;
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cache_stall,
    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data,
    input  logic              wb_we,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::word_t     wb_data
);

    import cpu_pkg::*;

    word_t regs [32];
    logic  write_en;

    // x0 is never written
    assign write_en = wb_we && !cache_stall && (wb_rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle write shows through to the readers
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (write_en && (wb_rd == rs1_addr)) begin
            rs1_data = wb_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (write_en && (wb_rd == rs2_addr)) begin
            rs2_data = wb_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cache_stall,
    input  cpu_pkg::word_t     pc,
    input  cpu_pkg::word_t     instr,
    input  logic               redirect,
    output cpu_pkg::reg_addr_t rs1_addr,
    output cpu_pkg::reg_addr_t rs2_addr,
    input  cpu_pkg::word_t     rs1_data,
    input  cpu_pkg::word_t     rs2_data,
    output logic               ex_valid,
    output logic               ex_use_imm,
    output logic               ex_rd_we,
    output cpu_pkg::word_t     ex_pc,
    output cpu_pkg::word_t     ex_imm,
    output cpu_pkg::word_t     ex_rs1_data,
    output cpu_pkg::word_t     ex_rs2_data,
    output cpu_pkg::alu_op_e   ex_alu_op,
    output cpu_pkg::branch_e   ex_branch,
    output cpu_pkg::reg_addr_t ex_rs1_addr,
    output cpu_pkg::reg_addr_t ex_rs2_addr,
    output cpu_pkg::reg_addr_t ex_rd
);

    import cpu_pkg::*;

    logic      id_valid;
    word_t     id_pc;
    word_t     id_instr;

    alu_op_e   dec_alu_op;
    branch_e   dec_branch;
    logic      dec_use_imm;
    logic      dec_writes;
    word_t     dec_imm;
    reg_addr_t dec_rd;
    logic      dec_rd_we;
    logic      [2:0] funct3;
    logic      alt;

    assign funct3   = id_instr[14:12];
    assign alt      = id_instr[30];
    assign rs1_addr = id_instr[19:15];
    assign rs2_addr = id_instr[24:20];
    assign dec_rd   = id_instr[11:7];

    // Valid bits, squashed by a taken branch in execute
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
        end else if (!cache_stall) begin
            id_valid <= !redirect;
            ex_valid <= id_valid && !redirect;
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk) begin
        if (!cache_stall) begin
            id_pc    <= pc;
            id_instr <= redirect ? nop_instr : instr;
        end
    end

    always_comb begin
        dec_alu_op  = alu_add;
        dec_branch  = br_none;
        dec_use_imm = 1'b0;
        dec_writes  = 1'b0;
        dec_imm     = {{20{id_instr[31]}}, id_instr[31:20]};
        case (id_instr[6:0])
            op_lui: begin
                dec_alu_op  = alu_pass_b;
                dec_use_imm = 1'b1;
                dec_writes  = 1'b1;
                dec_imm     = {id_instr[31:12], 12'b0};
            end
            op_imm, op_reg: begin
                dec_use_imm = (id_instr[6:0] == op_imm);
                dec_writes  = 1'b1;
                case (funct3)
                    3'b000:  dec_alu_op = (!dec_use_imm && alt) ? alu_sub : alu_add;
                    3'b001:  dec_alu_op = alu_sll;
                    3'b010:  dec_alu_op = alu_slt;
                    3'b011:  dec_alu_op = alu_sltu;
                    3'b100:  dec_alu_op = alu_xor;
                    3'b101:  dec_alu_op = alt ? alu_sra : alu_srl;
                    3'b110:  dec_alu_op = alu_or;
                    default: dec_alu_op = alu_and;
                endcase
            end
            op_branch: begin
                dec_imm = {{19{id_instr[31]}}, id_instr[31], id_instr[7],
                           id_instr[30:25], id_instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  dec_branch = br_eq;
                    3'b001:  dec_branch = br_ne;
                    3'b100:  dec_branch = br_lt;
                    3'b101:  dec_branch = br_ge;
                    3'b110:  dec_branch = br_ltu;
                    3'b111:  dec_branch = br_geu;
                    default: dec_branch = br_none;
                endcase
            end
            op_jal: begin
                dec_branch = br_jal;
                dec_writes = 1'b1;
                dec_imm    = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12],
                              id_instr[20], id_instr[30:21], 1'b0};
            end
            // Anything else passes through as a no-op
            default: begin
                dec_writes = 1'b0;
            end
        endcase
    end

    assign dec_rd_we = dec_writes && (dec_rd != '0);

    // Decode/execute register
    always_ff @(posedge clk) begin
        if (!cache_stall) begin
            ex_pc       <= id_pc;
            ex_alu_op   <= dec_alu_op;
            ex_branch   <= dec_branch;
            ex_use_imm  <= dec_use_imm;
            ex_imm      <= dec_imm;
            ex_rs1_addr <= rs1_addr;
            ex_rs2_addr <= rs2_addr;
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
            ex_rd       <= dec_rd;
            ex_rd_we    <= dec_rd_we;
        end
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cache_stall,
    input  logic               ex_valid,
    input  logic               ex_use_imm,
    input  logic               ex_rd_we,
    input  cpu_pkg::word_t     ex_pc,
    input  cpu_pkg::word_t     ex_imm,
    input  cpu_pkg::word_t     ex_rs1_data,
    input  cpu_pkg::word_t     ex_rs2_data,
    input  cpu_pkg::alu_op_e   ex_alu_op,
    input  cpu_pkg::branch_e   ex_branch,
    input  cpu_pkg::reg_addr_t ex_rs1_addr,
    input  cpu_pkg::reg_addr_t ex_rs2_addr,
    input  cpu_pkg::reg_addr_t ex_rd,
    output logic               redirect,
    output cpu_pkg::word_t     redirect_pc,
    output logic               wb_we,
    output cpu_pkg::reg_addr_t wb_rd,
    output cpu_pkg::word_t     wb_data,
    output logic               retire_valid,
    output cpu_pkg::word_t     retire_pc
);

    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_result;
    word_t result;
    logic  taken;
    logic  wb_valid;

    // Forward from the writeback register
    assign op_a  = (wb_we && (wb_rd == ex_rs1_addr)) ? wb_data : ex_rs1_data;
    assign op_b  = (wb_we && (wb_rd == ex_rs2_addr)) ? wb_data : ex_rs2_data;
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            alu_add:    alu_result = op_a + alu_b;
            alu_sub:    alu_result = op_a - alu_b;
            alu_sll:    alu_result = op_a << alu_b[4:0];
            alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(alu_b)};
            alu_sltu:   alu_result = {31'b0, op_a < alu_b};
            alu_xor:    alu_result = op_a ^ alu_b;
            alu_srl:    alu_result = op_a >> alu_b[4:0];
            alu_sra:    alu_result = $signed(op_a) >>> alu_b[4:0];
            alu_or:     alu_result = op_a | alu_b;
            alu_and:    alu_result = op_a & alu_b;
            default:    alu_result = alu_b;
        endcase
    end

    // Branch compare always uses the register operands
    always_comb begin
        case (ex_branch)
            br_eq:   taken = (op_a == op_b);
            br_ne:   taken = (op_a != op_b);
            br_lt:   taken = ($signed(op_a) < $signed(op_b));
            br_ge:   taken = ($signed(op_a) >= $signed(op_b));
            br_ltu:  taken = (op_a < op_b);
            br_geu:  taken = (op_a >= op_b);
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = ex_valid && taken;
    assign redirect_pc = ex_pc + ex_imm;

    // JAL links pc+4
    assign result = (ex_branch == br_jal) ? ex_pc + 32'd4 : alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else if (!cache_stall) begin
            wb_valid <= ex_valid;
            wb_we    <= ex_valid && ex_rd_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!cache_stall) begin
            wb_rd     <= ex_rd;
            wb_data   <= result;
            retire_pc <= ex_pc;
        end
    end

    // Held instruction retires on the first unstalled cycle
    assign retire_valid = wb_valid && !cache_stall;

endmodule

/* riscv_cpu.sv */
`timescale 1ns/10ps

module riscv_cpu #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     instr,
    input  logic               cache_stall,
    output cpu_pkg::word_t     pc,
    output logic               retire_valid,
    output logic               retire_we,
    output cpu_pkg::word_t     retire_pc,
    output cpu_pkg::word_t     retire_value,
    output cpu_pkg::reg_addr_t retire_rd
);

    import cpu_pkg::*;

    logic      redirect;
    word_t     redirect_pc;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    logic      ex_valid;
    logic      ex_use_imm;
    logic      ex_rd_we;
    word_t     ex_pc;
    word_t     ex_imm;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    alu_op_e   ex_alu_op;
    branch_e   ex_branch;
    reg_addr_t ex_rs1_addr;
    reg_addr_t ex_rs2_addr;
    reg_addr_t ex_rd;

    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    assign retire_we    = wb_we;
    assign retire_rd    = wb_rd;
    assign retire_value = wb_data;

    pc_unit #(
        .reset_pc(reset_pc)
    ) pc_inst0 (
        .clk(clk),
        .arst_n(arst_n),
        .cache_stall(cache_stall),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .pc(pc)
    );

    register_file rf_inst0 (
        .clk(clk),
        .arst_n(arst_n),
        .cache_stall(cache_stall),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb_we(wb_we),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    decode_stage decode_inst0 (
        .clk(clk),
        .arst_n(arst_n),
        .cache_stall(cache_stall),
        .pc(pc),
        .instr(instr),
        .redirect(redirect),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .ex_valid(ex_valid),
        .ex_use_imm(ex_use_imm),
        .ex_rd_we(ex_rd_we),
        .ex_pc(ex_pc),
        .ex_imm(ex_imm),
        .ex_rs1_data(ex_rs1_data),
        .ex_rs2_data(ex_rs2_data),
        .ex_alu_op(ex_alu_op),
        .ex_branch(ex_branch),
        .ex_rs1_addr(ex_rs1_addr),
        .ex_rs2_addr(ex_rs2_addr),
        .ex_rd(ex_rd)
    );

    execute_stage execute_inst0 (
        .clk(clk),
        .arst_n(arst_n),
        .cache_stall(cache_stall),
        .ex_valid(ex_valid),
        .ex_use_imm(ex_use_imm),
        .ex_rd_we(ex_rd_we),
        .ex_pc(ex_pc),
        .ex_imm(ex_imm),
        .ex_rs1_data(ex_rs1_data),
        .ex_rs2_data(ex_rs2_data),
        .ex_alu_op(ex_alu_op),
        .ex_branch(ex_branch),
        .ex_rs1_addr(ex_rs1_addr),
        .ex_rs2_addr(ex_rs2_addr),
        .ex_rd(ex_rd),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .wb_we(wb_we),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .retire_valid(retire_valid),
        .retire_pc(retire_pc)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // Release a quarter period after a rising edge, away from both edges
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #(period_ns / 4);
        arst_n = 1'b1;
    end

endmodule

/* tb_riscv_cpu.sv */
`timescale 1ns/10ps

module tb_riscv_cpu;

    localparam int num_retire     = 1000;
    localparam int reset_cycles   = 8;
    // Worst case of 3 cycles per taken jump plus about 20% stall cycles
    localparam int timeout_cycles = 4 * num_retire + reset_cycles + 16;

    logic        clk;
    logic        arst_n;
    logic        cache_stall;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        retire_valid;
    logic        retire_we;
    logic [31:0] retire_pc;
    logic [31:0] retire_value;
    logic [4:0]  retire_rd;

    logic [31:0] imem [64];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [31:0] stall_draw;
    integer      seed;
    int          retire_count = 0;
    int          cycle_count  = 0;
    int          edges_seen   = 0;
    logic        first_seen   = 1'b0;

    tb_clock_gen #(
        .period_ns(40),
        .reset_cycles(reset_cycles)
    ) clk_gen (
        .clk(clk),
        .arst_n(arst_n)
    );

    riscv_cpu #(
        .reset_pc(32'h0)
    ) dut (
        .clk(clk),
        .arst_n(arst_n),
        .instr(instr),
        .cache_stall(cache_stall),
        .pc(pc),
        .retire_valid(retire_valid),
        .retire_we(retire_we),
        .retire_pc(retire_pc),
        .retire_value(retire_value),
        .retire_rd(retire_rd)
    );

    // Instruction memory answers in the same cycle
    assign instr = imem[pc[7:2]];

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] k;
        logic [31:0] off;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        r   = next_random();
        imm = next_random();
        rd  = {2'b0, r[6:4]};
        rs1 = {2'b0, r[9:7]};
        rs2 = {2'b0, r[12:10]};
        f3  = r[15:13];
        // Going back 64-k words hits the same memory slot as k words forward
        k   = {29'b0, r[20:18]} + 32'd1;
        off = r[17] ? (32'd0 - (32'd64 - k) * 32'd4) : k * 32'd4;
        if (r[3:0] < 4'd2) begin
            return {imm[19:0], rd, 7'b0110111};
        end else if (r[3:0] < 4'd7) begin
            if (f3 == 3'd1) begin
                imm[11:5] = 7'b0;
            end else if (f3 == 3'd5) begin
                imm[11:5] = {1'b0, r[16], 5'b0};
            end
            return {imm[11:0], rs1, f3, rd, 7'b0010011};
        end else if (r[3:0] < 4'd12) begin
            return {1'b0, r[16] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd,
                    7'b0110011};
        end else if (r[3:0] < 4'd15) begin
            if (f3 == 3'd2 || f3 == 3'd3) begin
                f3 = f3 + 3'd4;
            end
            return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
        end else begin
            return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
        end
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic [31:0] a,
                                              input logic [31:0] b, input logic alt);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Executes one instruction at model_pc and updates the model registers
    task automatic model_step(input logic [31:0] w, output logic we, output logic [4:0] rd,
                              output logic [31:0] value, output logic [31:0] next_pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic        writes;
        rd      = w[11:7];
        f3      = w[14:12];
        a       = model_regs[w[19:15]];
        b       = model_regs[w[24:20]];
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        writes  = 1'b0;
        value   = '0;
        next_pc = model_pc + 32'd4;
        case (w[6:0])
            7'b0110111: begin
                value  = {w[31:12], 12'b0};
                writes = 1'b1;
            end
            7'b0010011: begin
                value  = alu_model(f3, a, imm_i, (f3 == 3'd5) && w[30]);
                writes = 1'b1;
            end
            7'b0110011: begin
                value  = alu_model(f3, a, b, w[30]);
                writes = 1'b1;
            end
            7'b1100011: begin
                case (f3)
                    3'd0: next_pc = (a == b) ? model_pc + imm_b : next_pc;
                    3'd1: next_pc = (a != b) ? model_pc + imm_b : next_pc;
                    3'd4: next_pc = ($signed(a) < $signed(b)) ? model_pc + imm_b : next_pc;
                    3'd5: next_pc = ($signed(a) >= $signed(b)) ? model_pc + imm_b : next_pc;
                    3'd6: next_pc = (a < b) ? model_pc + imm_b : next_pc;
                    3'd7: next_pc = (a >= b) ? model_pc + imm_b : next_pc;
                    default: next_pc = model_pc + 32'd4;
                endcase
            end
            7'b1101111: begin
                value   = model_pc + 32'd4;
                writes  = 1'b1;
                next_pc = model_pc + imm_j;
            end
            default: begin
                writes = 1'b0;
            end
        endcase
        we = writes && (rd != 5'd0);
        if (we) begin
            model_regs[rd] = value;
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_retire();
        logic [31:0] exp_value;
        logic [31:0] next_pc;
        logic [4:0]  exp_rd;
        logic        exp_we;
        model_step(imem[model_pc[7:2]], exp_we, exp_rd, exp_value, next_pc);
        assert (retire_pc == model_pc)
            else report_mismatch($sformatf("retire_pc %h, expected %h", retire_pc, model_pc));
        assert (retire_we == exp_we)
            else report_mismatch($sformatf("retire_we %b at pc %h", retire_we, model_pc));
        assert (!(retire_we && retire_rd == 5'd0))
            else report_mismatch("x0 reported as written");
        if (exp_we) begin
            assert (retire_rd == exp_rd)
                else report_mismatch($sformatf("retire_rd %0d, expected %0d", retire_rd, exp_rd));
            assert (retire_value == exp_value)
                else report_mismatch($sformatf("x%0d value %h, expected %h", exp_rd,
                                               retire_value, exp_value));
        end
        model_pc = next_pc;
        retire_count++;
    endtask

    // Retire outputs sampled on the falling edge
    always @(negedge clk) begin
        if (cycle_count > 0 && !arst_n) begin
            assert (pc == 32'h0 && !retire_valid)
                else report_mismatch("pc or retire_valid wrong during reset");
        end else if (arst_n) begin
            if (!first_seen) begin
                // First fetch reaches writeback after three unstalled edges
                assert (retire_valid == (edges_seen >= 3 && !cache_stall))
                    else report_mismatch($sformatf("retire_valid %b after %0d edges",
                                                   retire_valid, edges_seen));
            end
            if (retire_valid) begin
                first_seen = 1'b1;
                check_retire();
            end
            if (!cache_stall) begin
                edges_seen++;
            end
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            cache_stall <= 1'b0;
        end else begin
            stall_draw = next_random();
            cache_stall <= (stall_draw % 5 == 0);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout: %0d of %0d instructions retired after %0d cycles",
                     retire_count, num_retire, cycle_count);
            $display("Simulation FAILED");
            $fatal(1, "run did not finish in time");
        end
    end

    initial begin
        seed        = 72;
        cache_stall = 1'b0;
        model_pc    = 32'h0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            imem[i] = random_instr();
        end
        wait (retire_count >= num_retire);
        $display("%0d instructions retired in %0d cycles", retire_count, cycle_count);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* tb.f */
cpu_pkg.sv
pc_unit.sv
register_file.sv
decode_stage.sv
execute_stage.sv
riscv_cpu.sv
tb_clock_gen.sv
tb_riscv_cpu.sv
